//--- common/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Address and line geometry
    localparam int addr_w = 32;
    localparam int beat_w = 64;
    localparam int line_w = 256;
    localparam int beats_per_line = line_w / beat_w;
    localparam int beat_idx_w = $clog2(beats_per_line);
    localparam int words_per_line = line_w / 32;
    localparam int word_off_w = $clog2(words_per_line);

    // Direct-mapped cache split of the address
    localparam int num_sets = 16;
    localparam int offset_w = $clog2(line_w / 8);
    localparam int index_w = $clog2(num_sets);
    localparam int tag_w = addr_w - index_w - offset_w;

    // 32-bit words per instruction fetch
    localparam int fetch_words = 2;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              rmask;
        logic [3:0]        wmask;
        logic [31:0]       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              read;
        logic              write;
        logic [line_w-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              read;
        logic              write;
        logic [beat_w-1:0] wdata;
    } bmem_req_t;

    typedef struct packed {
        logic [beat_w-1:0] rdata;
        logic [addr_w-1:0] raddr;
        logic              rvalid;
    } bmem_rsp_t;

    typedef enum logic [1:0] {idle, compare, write_back, allocate} cache_state_e;

    typedef enum logic {wr_idle, wr_burst} arb_state_e;

    typedef enum logic {req_inst, req_data} requester_e;

endpackage

`default_nettype wire

//--- cache/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache #(
    parameter int read_words = 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pkg::cpu_req_t           cpu_req,
    output logic [32*read_words-1:0]    rdata,
    output logic                        resp,
    output mem_pkg::line_req_t          line_req,
    input  logic [mem_pkg::line_w-1:0]  line_rdata,
    input  logic                        line_resp
);

    import mem_pkg::*;

    cache_state_e state;

    // One line entry per set
    logic [tag_w-1:0]                      tag_arr [num_sets];
    logic [words_per_line-1:0][31:0]       data_arr [num_sets];
    logic [num_sets-1:0]                   valid_arr;
    logic [num_sets-1:0]                   dirty_arr;

    logic [tag_w-1:0]      req_tag;
    logic [index_w-1:0]    req_index;
    logic [word_off_w-1:0] req_word;
    logic                  req_valid;
    logic                  req_write;
    logic                  hit;
    logic                  do_fill;

    assign req_tag   = cpu_req.addr[addr_w-1 -: tag_w];
    assign req_index = cpu_req.addr[offset_w +: index_w];
    assign req_word  = cpu_req.addr[offset_w-1 -: word_off_w];
    assign req_write = |cpu_req.wmask;
    assign req_valid = cpu_req.rmask || req_write;

    assign hit     = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
    assign do_fill = (state == allocate) && line_resp;

    // Victim address on write-back and the requested line otherwise
    always_comb begin
        line_req.read  = (state == allocate);
        line_req.write = (state == write_back);
        line_req.wdata = data_arr[req_index];
        if (state == write_back) begin
            line_req.addr = {tag_arr[req_index], req_index, {offset_w{1'b0}}};
        end else begin
            line_req.addr = {req_tag, req_index, {offset_w{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            resp      <= 1'b0;
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            resp <= 1'b0;
            case (state)
                idle: begin
                    if (req_valid) begin
                        state <= compare;
                    end
                end
                compare: begin
                    if (hit) begin
                        resp  <= 1'b1;
                        state <= idle;
                        if (req_write) begin
                            dirty_arr[req_index] <= 1'b1;
                        end
                    end else if (valid_arr[req_index] && dirty_arr[req_index]) begin
                        state <= write_back;
                    end else begin
                        state <= allocate;
                    end
                end
                write_back: begin
                    if (line_resp) begin
                        state <= allocate;
                    end
                end
                allocate: begin
                    // Retry the compare once the new line is in place
                    if (line_resp) begin
                        state                <= compare;
                        valid_arr[req_index] <= 1'b1;
                        dirty_arr[req_index] <= 1'b0;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Tag and data arrays plus the read data register
    always_ff @(posedge clk) begin
        if (do_fill) begin
            data_arr[req_index] <= line_rdata;
            tag_arr[req_index]  <= req_tag;
        end else if ((state == compare) && hit && req_write) begin
            for (int b = 0; b < 4; b++) begin
                if (cpu_req.wmask[b]) begin
                    data_arr[req_index][req_word][8*b +: 8] <= cpu_req.wdata[8*b +: 8];
                end
            end
        end
        if ((state == compare) && hit) begin
            // Fetch words wrap within the line
            for (int i = 0; i < read_words; i++) begin
                rdata[32*i +: 32] <= data_arr[req_index][req_word + word_off_w'(i)];
            end
        end
    end

    // A line request stays up until the arbiter answers it
    a_line_req_hold: assert property (@(posedge clk) disable iff (rst)
        ((line_req.read || line_req.write) && !line_resp) |=>
            ($stable(line_req.read) && $stable(line_req.write) && $stable(line_req.addr)));

endmodule

`default_nettype wire

//--- arbiter/cache_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pkg::line_req_t          inst_line_req,
    input  mem_pkg::line_req_t          data_line_req,
    output logic [mem_pkg::line_w-1:0]  inst_line_rdata,
    output logic [mem_pkg::line_w-1:0]  data_line_rdata,
    output logic                        inst_line_resp,
    output logic                        data_line_resp,
    output mem_pkg::bmem_req_t          bmem_req,
    input  logic                        bmem_ready,
    input  mem_pkg::bmem_rsp_t          bmem_rsp
);

    import mem_pkg::*;

    typedef struct packed {
        logic              valid;
        requester_e        owner;
        logic [addr_w-1:0] addr;
    } rd_entry_t;

    rd_entry_t tbl [2];

    arb_state_e                                 wr_state;
    logic [beat_idx_w-1:0]                      wr_cnt;
    logic [beats_per_line-1:0][beat_w-1:0]      wr_line;
    logic [addr_w-1:0]                          wr_addr;
    requester_e                                 wr_owner;
    logic                                       wr_take;
    requester_e                                 wr_take_owner;
    logic                                       wr_done;

    logic [beats_per_line-2:0][beat_w-1:0]      rd_buf;
    logic [beat_idx_w-1:0]                      rd_cnt;
    logic                                       rd_done;
    logic [line_w-1:0]                          rd_line;

    logic              rd_go;
    requester_e        rd_owner;
    logic [addr_w-1:0] rd_addr;
    logic              rd_hold;
    requester_e        rd_hold_owner;
    logic              inst_busy;
    logic              data_busy;
    logic [1:0]        match_vec;
    logic              match_idx;
    logic              free_idx;

    always_comb begin
        inst_busy = 1'b0;
        data_busy = 1'b0;
        for (int i = 0; i < 2; i++) begin
            match_vec[i] = tbl[i].valid && (tbl[i].addr == bmem_rsp.raddr);
            if (tbl[i].valid && tbl[i].owner == req_inst) inst_busy = 1'b1;
            if (tbl[i].valid && tbl[i].owner == req_data) data_busy = 1'b1;
        end
    end

    assign match_idx = match_vec[1];
    assign free_idx  = tbl[0].valid;

    // Instruction reads go first and nothing new starts during a write burst
    always_comb begin
        rd_go         = 1'b0;
        rd_owner      = req_inst;
        wr_take       = 1'b0;
        wr_take_owner = req_inst;
        if (wr_state == wr_idle) begin
            if (rd_hold) begin
                rd_go    = 1'b1;
                rd_owner = rd_hold_owner;
            end else if (inst_line_req.read && !inst_busy) begin
                rd_go = 1'b1;
            end else if (data_line_req.read && !data_busy) begin
                rd_go    = 1'b1;
                rd_owner = req_data;
            end else if (inst_line_req.write) begin
                wr_take = 1'b1;
            end else if (data_line_req.write) begin
                wr_take       = 1'b1;
                wr_take_owner = req_data;
            end
        end
    end

    assign rd_addr = (rd_owner == req_inst) ? inst_line_req.addr : data_line_req.addr;

    always_comb begin
        bmem_req = '0;
        if (wr_state == wr_burst) begin
            bmem_req.addr  = wr_addr;
            bmem_req.write = 1'b1;
            bmem_req.wdata = wr_line[wr_cnt];
        end else if (rd_go) begin
            bmem_req.addr = rd_addr;
            bmem_req.read = 1'b1;
        end
    end

    assign wr_done = (wr_state == wr_burst) && bmem_ready &&
                     (wr_cnt == beat_idx_w'(beats_per_line - 1));
    assign rd_done = bmem_rsp.rvalid && (rd_cnt == beat_idx_w'(beats_per_line - 1));
    assign rd_line = {bmem_rsp.rdata, rd_buf};

    // The assembled line goes to both caches and only the owner sees resp
    assign inst_line_rdata = rd_line;
    assign data_line_rdata = rd_line;
    assign inst_line_resp  = (wr_done && wr_owner == req_inst) ||
                             (rd_done && tbl[match_idx].owner == req_inst);
    assign data_line_resp  = (wr_done && wr_owner == req_data) ||
                             (rd_done && tbl[match_idx].owner == req_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= wr_idle;
            wr_cnt   <= '0;
            rd_cnt   <= '0;
            rd_hold  <= 1'b0;
            tbl[0]   <= '0;
            tbl[1]   <= '0;
        end else begin
            if (wr_take) begin
                wr_state <= wr_burst;
                wr_cnt   <= '0;
            end else if (wr_state == wr_burst && bmem_ready) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_done) wr_state <= wr_idle;
            end
            rd_hold <= rd_go && !bmem_ready;
            if (rd_go && bmem_ready) begin
                tbl[free_idx] <= '{valid: 1'b1, owner: rd_owner, addr: rd_addr};
            end
            if (bmem_rsp.rvalid) rd_cnt <= rd_cnt + 1'b1;
            if (rd_done) tbl[match_idx].valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            wr_line  <= (wr_take_owner == req_inst) ? inst_line_req.wdata : data_line_req.wdata;
            wr_addr  <= (wr_take_owner == req_inst) ? inst_line_req.addr : data_line_req.addr;
            wr_owner <= wr_take_owner;
        end
        if (rd_go) rd_hold_owner <= rd_owner;
        if (bmem_rsp.rvalid && !rd_done) rd_buf[rd_cnt] <= bmem_rsp.rdata;
    end

    a_rvalid_known: assert property (@(posedge clk) disable iff (rst)
        bmem_rsp.rvalid |-> (|match_vec));

endmodule

`default_nettype wire

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  logic                                clk,
    input  logic                                rst,
    input  mem_pkg::cpu_req_t                   inst_req,
    input  mem_pkg::cpu_req_t                   data_req,
    output logic [32*mem_pkg::fetch_words-1:0]  inst_rdata,
    output logic                                inst_resp,
    output logic [31:0]                         data_rdata,
    output logic                                data_resp,
    output mem_pkg::bmem_req_t                  bmem_req,
    input  logic                                bmem_ready,
    input  mem_pkg::bmem_rsp_t                  bmem_rsp
);

    import mem_pkg::*;

    line_req_t         inst_line_req;
    line_req_t         data_line_req;
    logic [line_w-1:0] inst_line_rdata;
    logic [line_w-1:0] data_line_rdata;
    logic              inst_line_resp;
    logic              data_line_resp;

    // Fetch side returns two words per hit
    cache #(
        .read_words(fetch_words)
    ) inst_cache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (inst_req),
        .rdata      (inst_rdata),
        .resp       (inst_resp),
        .line_req   (inst_line_req),
        .line_rdata (inst_line_rdata),
        .line_resp  (inst_line_resp)
    );

    cache #(
        .read_words(1)
    ) data_cache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (data_req),
        .rdata      (data_rdata),
        .resp       (data_resp),
        .line_req   (data_line_req),
        .line_rdata (data_line_rdata),
        .line_resp  (data_line_resp)
    );

    cache_arbiter arbiter0 (
        .clk             (clk),
        .rst             (rst),
        .inst_line_req   (inst_line_req),
        .data_line_req   (data_line_req),
        .inst_line_rdata (inst_line_rdata),
        .data_line_rdata (data_line_rdata),
        .inst_line_resp  (inst_line_resp),
        .data_line_resp  (data_line_resp),
        .bmem_req        (bmem_req),
        .bmem_ready      (bmem_ready),
        .bmem_rsp        (bmem_rsp)
    );

endmodule

`default_nettype wire

//--- dv/bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module bmem_model (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::bmem_req_t  bmem_req,
    output logic                bmem_ready,
    output mem_pkg::bmem_rsp_t  bmem_rsp
);

    import mem_pkg::*;

    // Sparse store of written beats, keyed by beat address
    logic [beat_w-1:0] store [logic [addr_w-1:0]];

    // Read bursts waiting to be returned, in request order
    logic [line_w-1:0] rd_lines [$];
    logic [addr_w-1:0] rd_addrs [$];

    logic              ready_q = 1'b0;
    bmem_rsp_t         rsp_q = '0;
    int unsigned       wr_beat = 0;
    logic [line_w-1:0] fill_line;
    logic              busy = 1'b0;
    logic [line_w-1:0] cur_line;
    logic [addr_w-1:0] cur_addr;
    int unsigned       cur_beat = 0;

    assign bmem_ready = ready_q;
    assign bmem_rsp   = rsp_q;

    function automatic logic [7:0] init_byte(input logic [addr_w-1:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [beat_w-1:0] load_beat(input logic [addr_w-1:0] a);
        logic [beat_w-1:0] b;
        if (store.exists(a)) begin
            b = store[a];
        end else begin
            for (int k = 0; k < 8; k++) begin
                b[8*k +: 8] = init_byte(a + addr_w'(k));
            end
        end
        return b;
    endfunction

    // Accept beats on the rising edge, the same edge the arbiter sees
    always @(posedge clk) begin
        if (!rst && ready_q) begin
            if (bmem_req.write) begin
                store[bmem_req.addr + addr_w'(8 * wr_beat)] = bmem_req.wdata;
                wr_beat = (wr_beat + 1) % beats_per_line;
            end else if (bmem_req.read) begin
                for (int b = 0; b < beats_per_line; b++) begin
                    fill_line[beat_w*b +: beat_w] = load_beat(bmem_req.addr + addr_w'(8 * b));
                end
                rd_lines.push_back(fill_line);
                rd_addrs.push_back(bmem_req.addr);
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            ready_q  = 1'b0;
            rsp_q    = '0;
            busy     = 1'b0;
            cur_beat = 0;
        end else begin
            // Roughly one cycle in four stalls
            ready_q = ($urandom % 4) != 0;
            rsp_q   = '0;
            // Geometric wait before a burst starts
            if (!busy && rd_lines.size() > 0 && ($urandom % 3) == 0) begin
                cur_line = rd_lines.pop_front();
                cur_addr = rd_addrs.pop_front();
                busy     = 1'b1;
                cur_beat = 0;
            end
            // Idle gaps between beats
            if (busy && ($urandom % 4) != 0) begin
                rsp_q.rdata  = cur_line[beat_w*cur_beat +: beat_w];
                rsp_q.raddr  = cur_addr;
                rsp_q.rvalid = 1'b1;
                cur_beat++;
                if (cur_beat == beats_per_line) begin
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    import mem_pkg::*;

    localparam int n_fetch = 48;
    localparam int n_read = 32;
    localparam int n_write = 32;
    localparam int n_evict = 4;
    localparam int n_mixed = 40;
    localparam int total_reqs = n_fetch + n_read + 2 * n_write + 3 * n_evict + 2 * n_mixed;
    localparam int watchdog_ns = total_reqs * 400 * 40;

    // Disjoint regions for the two streams
    localparam logic [addr_w-1:0] inst_base = 32'h0000_1000;
    localparam logic [addr_w-1:0] data_base = 32'h0000_8000;

    logic                      clk = 1'b0;
    logic                      rst;
    cpu_req_t                  inst_req;
    cpu_req_t                  data_req;
    logic [32*fetch_words-1:0] inst_rdata;
    logic                      inst_resp;
    logic [31:0]               data_rdata;
    logic                      data_resp;
    bmem_req_t                 bmem_req;
    logic                      bmem_ready;
    bmem_rsp_t                 bmem_rsp;

    logic [7:0]  ref_mem [logic [addr_w-1:0]];
    int          checks = 0;
    int          errors = 0;
    int          mark_checks;
    int          mark_errors;

    always #20 clk = ~clk;

    mem_subsystem dut0 (
        .clk        (clk),
        .rst        (rst),
        .inst_req   (inst_req),
        .data_req   (data_req),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .bmem_req   (bmem_req),
        .bmem_ready (bmem_ready),
        .bmem_rsp   (bmem_rsp)
    );

    bmem_model bmem0 (
        .clk        (clk),
        .rst        (rst),
        .bmem_req   (bmem_req),
        .bmem_ready (bmem_ready),
        .bmem_rsp   (bmem_rsp)
    );

    function automatic logic [7:0] init_byte(input logic [addr_w-1:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [7:0] ref_byte(input logic [addr_w-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : init_byte(a);
    endfunction

    // Little-endian word from the reference memory
    function automatic logic [31:0] ref_word(input logic [addr_w-1:0] a);
        return {ref_byte(a + 32'd3), ref_byte(a + 32'd2), ref_byte(a + 32'd1), ref_byte(a)};
    endfunction

    function automatic logic [addr_w-1:0] rand_inst_addr();
        return inst_base + (($urandom % 256) << 2);
    endfunction

    function automatic logic [addr_w-1:0] rand_data_addr();
        return data_base + (($urandom % 512) << 2);
    endfunction

    task automatic compare_value(input string name, input logic [addr_w-1:0] addr,
                                 input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h (addr %h)", name, expected, actual, addr);
        end
    endtask

    task automatic fetch_check(input string name, input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] next_addr;
        logic [63:0]       expected;
        // Second word wraps within the 32-byte line
        next_addr = {addr[addr_w-1:5], addr[4:2] + 3'd1, 2'b00};
        expected  = {ref_word(next_addr), ref_word(addr)};
        @(negedge clk);
        inst_req = '{addr: addr, rmask: 1'b1, wmask: 4'h0, wdata: 32'h0};
        @(negedge clk);
        while (!inst_resp) @(negedge clk);
        inst_req = '0;
        compare_value(name, addr, expected, inst_rdata);
    endtask

    task automatic data_read_check(input string name, input logic [addr_w-1:0] addr);
        logic [31:0] expected;
        expected = ref_word(addr);
        @(negedge clk);
        data_req = '{addr: addr, rmask: 1'b1, wmask: 4'h0, wdata: 32'h0};
        @(negedge clk);
        while (!data_resp) @(negedge clk);
        data_req = '0;
        compare_value(name, addr, {32'h0, expected}, {32'h0, data_rdata});
    endtask

    task automatic data_write(input logic [addr_w-1:0] addr, input logic [3:0] mask,
                              input logic [31:0] wdata);
        @(negedge clk);
        data_req = '{addr: addr, rmask: 1'b0, wmask: mask, wdata: wdata};
        @(negedge clk);
        while (!data_resp) @(negedge clk);
        data_req = '0;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) ref_mem[addr + addr_w'(b)] = wdata[8*b +: 8];
        end
    endtask

    task automatic random_data_op(input string name);
        logic [addr_w-1:0] a;
        a = rand_data_addr();
        if ($urandom % 2 == 0) begin
            data_write(a, 4'(($urandom % 15) + 1), $urandom);
        end else begin
            data_read_check(name, a);
        end
    endtask

    task automatic mark_test_start();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic report_test(input string name);
        $display("%-16s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
    endtask

    initial begin
        logic [addr_w-1:0] a;
        void'($urandom(32'h50c8_7a70));
        rst      = 1'b1;
        inst_req = '0;
        data_req = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        mark_test_start();
        for (int i = 0; i < n_fetch; i++) fetch_check("inst_fetch", rand_inst_addr());
        report_test("inst_fetch");

        mark_test_start();
        for (int i = 0; i < n_read; i++) data_read_check("data_read", rand_data_addr());
        report_test("data_read");

        mark_test_start();
        for (int i = 0; i < n_write; i++) begin
            a = rand_data_addr();
            data_write(a, 4'(($urandom % 15) + 1), $urandom);
            data_read_check("data_write", a);
        end
        report_test("data_write");

        // Same index, different tag forces the dirty line out and back
        mark_test_start();
        for (int i = 0; i < n_evict; i++) begin
            a = rand_data_addr();
            data_write(a, 4'hf, $urandom);
            data_read_check("conflict_evict", a + (num_sets << offset_w));
            data_read_check("conflict_evict", a);
        end
        report_test("conflict_evict");

        mark_test_start();
        fork
            begin
                for (int i = 0; i < n_mixed; i++) fetch_check("mixed_traffic", rand_inst_addr());
            end
            begin
                for (int i = 0; i < n_mixed; i++) random_data_op("mixed_traffic");
            end
        join
        report_test("mixed_traffic");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog timeout: a request got no response in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsystem.f
common/mem_pkg.sv
cache/cache.sv
arbiter/cache_arbiter.sv
verilog/mem_subsystem.sv
dv/bmem_model.sv
dv/tb_mem_subsystem.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_subsystem
FILELIST   := mem_subsystem.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG   := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
